// File: rtl/lc4_pkg.sv
// shared widths, encodings and enums for the LC4 pipeline
// compile first; other files refer to it with lc4_pkg:: names
package lc4_pkg;

    localparam int XLEN   = 16;
    localparam int RSEL_W = 3;

    typedef logic [XLEN-1:0]   word_t;   // data, pc and instruction
    typedef logic [RSEL_W-1:0] rsel_t;
    typedef logic [2:0]        nzp_t;    // {n, z, p}

    // insn[15:12]
    typedef enum logic [3:0] {
        OP_BR    = 4'h0,
        OP_ARITH = 4'h1,
        OP_LOGIC = 4'h5,
        OP_LDR   = 4'h6,
        OP_STR   = 4'h7,
        OP_CONST = 4'h9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CONST,   // sext imm9
        ALU_BRTGT    // pc + 1 + sext imm9
    } alu_op_e;

    // code carried with each slot down to the trace port
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

    // operand source for the execute and store-data muxes
    typedef enum logic [1:0] {
        BYP_NONE,
        BYP_M,
        BYP_W
    } byp_e;

    localparam word_t DEFAULT_RESET_PC = 16'h8200;

endpackage

// File: rtl/lc4_decoder.sv
// instruction decode for the LC4 subset
// gives register selects, read/write enables, load/store/branch flags and the ALU op
// anything outside the subset comes out with every enable low
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_pkg::word_t   i_insn,
    output lc4_pkg::rsel_t   o_rs_sel,
    output lc4_pkg::rsel_t   o_rt_sel,
    output lc4_pkg::rsel_t   o_rd_sel,
    output logic             o_rs_re,
    output logic             o_rt_re,
    output logic             o_rd_we,
    output logic             o_nzp_we,
    output logic             o_is_load,
    output logic             o_is_store,
    output logic             o_is_branch,
    output lc4_pkg::alu_op_e o_alu_op
);

    lc4_pkg::opcode_e opcode;
    logic             imm_form;   // insn[5] picks IMM5 for ADDI / ANDI

    assign opcode   = lc4_pkg::opcode_e'(i_insn[15:12]);
    assign imm_form = i_insn[5];

    assign o_rs_sel = i_insn[8:6];
    assign o_rd_sel = i_insn[11:9];
    // STR keeps its data register where other formats keep rd
    assign o_rt_sel = (opcode == lc4_pkg::OP_STR) ? i_insn[11:9] : i_insn[2:0];

    always_comb begin
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        o_rd_we     = 1'b0;
        o_nzp_we    = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;
        o_alu_op    = lc4_pkg::ALU_ADD;
        case (opcode)
            lc4_pkg::OP_BR: begin
                o_is_branch = 1'b1;
                o_alu_op    = lc4_pkg::ALU_BRTGT;
            end
            lc4_pkg::OP_ARITH: begin
                // ADD, SUB, ADDI only; MUL and DIV fall out as no-ops
                if (imm_form || i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = !imm_form;
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                    o_alu_op = (i_insn[5:3] == 3'b010) ? lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                if (i_insn[5:3] != 3'b001) begin   // NOT is outside the subset
                    o_rs_re  = 1'b1;
                    o_rt_re  = !imm_form;
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                    case (i_insn[5:3])
                        3'b010:  o_alu_op = lc4_pkg::ALU_OR;
                        3'b011:  o_alu_op = lc4_pkg::ALU_XOR;
                        default: o_alu_op = lc4_pkg::ALU_AND;
                    endcase
                end
            end
            lc4_pkg::OP_LDR: begin
                o_rs_re   = 1'b1;
                o_rd_we   = 1'b1;
                o_nzp_we  = 1'b1;
                o_is_load = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            lc4_pkg::OP_CONST: begin
                o_rd_we  = 1'b1;
                o_nzp_we = 1'b1;
                o_alu_op = lc4_pkg::ALU_CONST;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/lc4_alu.sv
// execute-stage ALU
// second operand is rt, IMM5 (ADDI/ANDI) or IMM6 (LDR/STR address)
// also forms CONST values and branch targets from the execute pc
`timescale 1ns/1ps

module lc4_alu (
    input  logic             gwe,
    input  logic             i_arst_n,
    input  lc4_pkg::alu_op_e i_alu_op,
    input  lc4_pkg::word_t   i_insn,
    input  lc4_pkg::word_t   i_pc,
    input  lc4_pkg::word_t   i_rs_data,
    input  lc4_pkg::word_t   i_rt_data,
    output lc4_pkg::word_t   o_result
);

    lc4_pkg::word_t imm5, imm6, imm9;
    lc4_pkg::word_t opnd_b;
    logic           mem_form;

    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    assign mem_form = (i_insn[15:12] == lc4_pkg::OP_LDR) || (i_insn[15:12] == lc4_pkg::OP_STR);
    assign opnd_b   = mem_form  ? imm6 :
                      i_insn[5] ? imm5 :   // immediate form of ADD / AND
                      i_rt_data;

    always_comb begin
        case (i_alu_op)
            lc4_pkg::ALU_SUB:   o_result = i_rs_data - opnd_b;
            lc4_pkg::ALU_AND:   o_result = i_rs_data & opnd_b;
            lc4_pkg::ALU_OR:    o_result = i_rs_data | opnd_b;
            lc4_pkg::ALU_XOR:   o_result = i_rs_data ^ opnd_b;
            lc4_pkg::ALU_CONST: o_result = imm9;
            lc4_pkg::ALU_BRTGT: o_result = i_pc + 16'd1 + imm9;
            default:            o_result = i_rs_data + opnd_b;   // add, addi, address
        endcase
    end

    // the X stage always holds a decoded op once reset has flushed the pipe
    a_op_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        !$isunknown(i_alu_op));

endmodule

// File: rtl/lc4_regfile.sv
// eight 16-bit registers, two read ports and one write port
// a read of the register written this cycle returns the new data,
// which gives the writeback-to-decode bypass
`timescale 1ns/1ps

module lc4_regfile (
    input  logic           gwe,
    input  logic           i_arst_n,
    input  lc4_pkg::rsel_t i_rs_sel,
    input  lc4_pkg::rsel_t i_rt_sel,
    input  lc4_pkg::rsel_t i_rd_sel,
    input  logic           i_rd_we,
    input  lc4_pkg::word_t i_rd_data,
    output lc4_pkg::word_t o_rs_data,
    output lc4_pkg::word_t o_rt_data
);

    localparam int NREGS = 2 ** lc4_pkg::RSEL_W;

    lc4_pkg::word_t regs [NREGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            regs <= '{default: '0};
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

// File: rtl/lc4_hazard_unit.sv
// load-to-use stall detection and bypass source selection
// execute operands take M first, then W; store data in M takes W
`timescale 1ns/1ps

module lc4_hazard_unit (
    input  logic           gwe,
    input  logic           i_arst_n,
    input  lc4_pkg::rsel_t i_d_rs_sel,
    input  lc4_pkg::rsel_t i_d_rt_sel,
    input  logic           i_d_rs_re,
    input  logic           i_d_rt_re,
    input  logic           i_d_is_store,
    input  logic           i_d_is_branch,
    input  lc4_pkg::rsel_t i_x_rs_sel,
    input  lc4_pkg::rsel_t i_x_rt_sel,
    input  lc4_pkg::rsel_t i_x_rd_sel,
    input  logic           i_x_is_load,
    input  lc4_pkg::rsel_t i_m_rt_sel,
    input  lc4_pkg::rsel_t i_m_rd_sel,
    input  logic           i_m_rd_we,
    input  logic           i_m_is_store,
    input  lc4_pkg::rsel_t i_w_rd_sel,
    input  logic           i_w_rd_we,
    output logic           o_load_stall,
    output lc4_pkg::byp_e  o_byp_x_rs,
    output lc4_pkg::byp_e  o_byp_x_rt,
    output lc4_pkg::byp_e  o_byp_m_st
);

    logic rs_dep, rt_dep;

    function automatic lc4_pkg::byp_e x_src(input lc4_pkg::rsel_t sel);
        if (i_m_rd_we && i_m_rd_sel == sel)
            return lc4_pkg::BYP_M;
        if (i_w_rd_we && i_w_rd_sel == sel)
            return lc4_pkg::BYP_W;
        return lc4_pkg::BYP_NONE;
    endfunction

    assign rs_dep = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
    // store data reaches M a cycle later, WM covers it
    assign rt_dep = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);

    // a branch waits for the load's nzp regardless of registers
    assign o_load_stall = i_x_is_load && (rs_dep || rt_dep || i_d_is_branch);

    always_comb begin
        o_byp_x_rs = x_src(i_x_rs_sel);
        o_byp_x_rt = x_src(i_x_rt_sel);
        o_byp_m_st = lc4_pkg::BYP_NONE;
        if (i_m_is_store && i_w_rd_we && i_w_rd_sel == i_m_rt_sel)
            o_byp_m_st = lc4_pkg::BYP_W;   // WM path
    end

    // the stalled decode slot stays put while a bubble moves into execute
    a_single_bubble: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_load_stall |=> !i_x_is_load && $stable(i_d_rs_sel) && $stable(i_d_rt_sel));

endmodule

// File: rtl/lc4_pipeline.sv
// five-stage single-issue LC4 pipeline, top level
// fetch and data memory answer in the same cycle; results retire on the trace ports
// branches resolve in execute and flush the two younger slots
`timescale 1ns/1ps

module lc4_pipeline #(
    parameter lc4_pkg::word_t RESET_PC = lc4_pkg::DEFAULT_RESET_PC
) (
    input  logic             gwe,
    input  logic             i_arst_n,
    input  lc4_pkg::word_t   i_cur_insn,
    input  lc4_pkg::word_t   i_cur_dmem_data,
    output lc4_pkg::word_t   o_cur_pc,
    output lc4_pkg::word_t   o_dmem_addr,
    output lc4_pkg::word_t   o_dmem_towrite,
    output logic             o_dmem_we,
    output lc4_pkg::stall_e  o_trace_stall,
    output lc4_pkg::word_t   o_trace_pc,
    output lc4_pkg::word_t   o_trace_insn,
    output logic             o_trace_rd_we,
    output lc4_pkg::rsel_t   o_trace_rd_sel,
    output lc4_pkg::word_t   o_trace_rd_data,
    output logic             o_trace_nzp_we,
    output lc4_pkg::nzp_t    o_trace_nzp,
    output logic             o_trace_dmem_we,
    output lc4_pkg::word_t   o_trace_dmem_addr,
    output lc4_pkg::word_t   o_trace_dmem_data
);

    lc4_pkg::word_t   pc, d_insn, d_pc;
    lc4_pkg::stall_e  d_stall, x_stall, m_stall, w_stall;
    lc4_pkg::rsel_t   dec_rs_sel, dec_rt_sel, dec_rd_sel;
    logic             dec_rs_re, dec_rt_re, dec_rd_we, dec_nzp_we;
    logic             dec_is_load, dec_is_store, dec_is_branch;
    lc4_pkg::alu_op_e dec_alu_op, x_alu_op;
    lc4_pkg::word_t   rf_rs_data, rf_rt_data;

    lc4_pkg::word_t   x_insn, x_pc, x_rs_data, x_rt_data, x_rs_val, x_rt_val, x_result;
    lc4_pkg::rsel_t   x_rs_sel, x_rt_sel, x_rd_sel;
    logic             x_rd_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
    logic             x_kill, br_taken;

    lc4_pkg::word_t   m_insn, m_pc, m_result, m_rt_data, m_st_data, m_mem_data;
    lc4_pkg::rsel_t   m_rt_sel, m_rd_sel;
    logic             m_rd_we, m_nzp_we, m_is_load, m_is_store;

    lc4_pkg::word_t   w_insn, w_pc, w_result, w_mem_addr, w_mem_data, wb_data;
    lc4_pkg::rsel_t   w_rd_sel;
    logic             w_rd_we, w_nzp_we, w_is_load, w_is_store;

    lc4_pkg::nzp_t    nzp_reg;
    logic             load_stall;
    lc4_pkg::byp_e    byp_x_rs, byp_x_rt, byp_m_st;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
        if (v == '0)
            return 3'b010;
        return v[lc4_pkg::XLEN-1] ? 3'b100 : 3'b001;
    endfunction

    function automatic lc4_pkg::word_t byp_mux(input lc4_pkg::byp_e sel,
                                               input lc4_pkg::word_t from_m,
                                               input lc4_pkg::word_t from_w,
                                               input lc4_pkg::word_t from_reg);
        case (sel)
            lc4_pkg::BYP_M: return from_m;
            lc4_pkg::BYP_W: return from_w;
            default:        return from_reg;
        endcase
    endfunction

    // fetch: hold on a load stall, redirect on a taken branch
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= RESET_PC;
            d_insn  <= '0;
            d_pc    <= '0;
            d_stall <= lc4_pkg::STALL_BRANCH;
        end else if (br_taken) begin
            pc      <= x_result;
            d_insn  <= '0;                     // fetched slot is squashed
            d_pc    <= '0;
            d_stall <= lc4_pkg::STALL_BRANCH;
        end else if (!load_stall) begin
            pc      <= pc + 16'd1;
            d_insn  <= i_cur_insn;
            d_pc    <= pc;
            d_stall <= lc4_pkg::STALL_NONE;
        end
    end

    lc4_decoder decoder_i (
        .i_insn(d_insn),
        .o_rs_sel(dec_rs_sel), .o_rt_sel(dec_rt_sel), .o_rd_sel(dec_rd_sel),
        .o_rs_re(dec_rs_re), .o_rt_re(dec_rt_re),
        .o_rd_we(dec_rd_we), .o_nzp_we(dec_nzp_we),
        .o_is_load(dec_is_load), .o_is_store(dec_is_store), .o_is_branch(dec_is_branch),
        .o_alu_op(dec_alu_op)
    );

    lc4_regfile regfile_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_sel(dec_rs_sel), .i_rt_sel(dec_rt_sel),
        .i_rd_sel(w_rd_sel), .i_rd_we(w_rd_we), .i_rd_data(wb_data),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

    lc4_hazard_unit hazard_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_d_rs_sel(dec_rs_sel), .i_d_rt_sel(dec_rt_sel),
        .i_d_rs_re(dec_rs_re), .i_d_rt_re(dec_rt_re),
        .i_d_is_store(dec_is_store), .i_d_is_branch(dec_is_branch),
        .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel), .i_x_rd_sel(x_rd_sel),
        .i_x_is_load(x_is_load),
        .i_m_rt_sel(m_rt_sel), .i_m_rd_sel(m_rd_sel),
        .i_m_rd_we(m_rd_we), .i_m_is_store(m_is_store),
        .i_w_rd_sel(w_rd_sel), .i_w_rd_we(w_rd_we),
        .o_load_stall(load_stall),
        .o_byp_x_rs(byp_x_rs), .o_byp_x_rt(byp_x_rt), .o_byp_m_st(byp_m_st)
    );

    // D -> X, a bubble goes in on a flush or a load stall
    assign x_kill = br_taken || load_stall;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_insn      <= '0;
            x_pc        <= '0;
            x_stall     <= lc4_pkg::STALL_BRANCH;
            x_rd_we     <= 1'b0;
            x_nzp_we    <= 1'b0;
            x_is_load   <= 1'b0;
            x_is_store  <= 1'b0;
            x_is_branch <= 1'b0;
        end else begin
            x_insn      <= x_kill ? '0 : d_insn;
            x_pc        <= x_kill ? '0 : d_pc;
            x_stall     <= br_taken   ? lc4_pkg::STALL_BRANCH :
                           load_stall ? lc4_pkg::STALL_LOAD : d_stall;
            x_rd_we     <= dec_rd_we && !x_kill;
            x_nzp_we    <= dec_nzp_we && !x_kill;
            x_is_load   <= dec_is_load && !x_kill;
            x_is_store  <= dec_is_store && !x_kill;
            x_is_branch <= dec_is_branch && !x_kill;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_sel  <= dec_rs_sel;
        x_rt_sel  <= dec_rt_sel;
        x_rd_sel  <= dec_rd_sel;
        x_alu_op  <= dec_alu_op;
        x_rs_data <= rf_rs_data;
        x_rt_data <= rf_rt_data;
    end

    assign x_rs_val = byp_mux(byp_x_rs, m_result, wb_data, x_rs_data);   // MX / WX
    assign x_rt_val = byp_mux(byp_x_rt, m_result, wb_data, x_rt_data);

    lc4_alu alu_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_alu_op(x_alu_op), .i_insn(x_insn), .i_pc(x_pc),
        .i_rs_data(x_rs_val), .i_rt_data(x_rt_val),
        .o_result(x_result)
    );

    assign br_taken = x_is_branch && |(nzp_reg & x_insn[11:9]);

    // younger writer in X wins over a load finishing in M
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n)
            nzp_reg <= '0;
        else if (x_nzp_we && !x_is_load)
            nzp_reg <= nzp_of(x_result);
        else if (m_is_load)
            nzp_reg <= nzp_of(i_cur_dmem_data);
    end

    // X -> M
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_insn     <= '0;
            m_pc       <= '0;
            m_stall    <= lc4_pkg::STALL_BRANCH;
            m_rd_we    <= 1'b0;
            m_nzp_we   <= 1'b0;
            m_is_load  <= 1'b0;
            m_is_store <= 1'b0;
        end else begin
            m_insn     <= x_insn;
            m_pc       <= x_pc;
            m_stall    <= x_stall;
            m_rd_we    <= x_rd_we;
            m_nzp_we   <= x_nzp_we;
            m_is_load  <= x_is_load;
            m_is_store <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        m_rt_sel  <= x_rt_sel;
        m_rd_sel  <= x_rd_sel;
        m_result  <= x_result;
        m_rt_data <= x_rt_val;
    end

    assign m_st_data      = byp_mux(byp_m_st, m_result, wb_data, m_rt_data);   // WM
    assign o_dmem_addr    = (m_is_load || m_is_store) ? m_result : '0;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = m_st_data;
    assign m_mem_data     = m_is_load  ? i_cur_dmem_data :
                            m_is_store ? m_st_data : '0;

    // M -> W
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            w_insn     <= '0;
            w_pc       <= '0;
            w_stall    <= lc4_pkg::STALL_BRANCH;
            w_rd_we    <= 1'b0;
            w_nzp_we   <= 1'b0;
            w_is_load  <= 1'b0;
            w_is_store <= 1'b0;
        end else begin
            w_insn     <= m_insn;
            w_pc       <= m_pc;
            w_stall    <= m_stall;
            w_rd_we    <= m_rd_we;
            w_nzp_we   <= m_nzp_we;
            w_is_load  <= m_is_load;
            w_is_store <= m_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        w_rd_sel   <= m_rd_sel;
        w_result   <= m_result;
        w_mem_addr <= o_dmem_addr;
        w_mem_data <= m_mem_data;
    end

    assign wb_data = w_is_load ? w_mem_data : w_result;

    assign o_cur_pc          = pc;
    assign o_trace_stall     = w_stall;
    assign o_trace_pc        = w_pc;
    assign o_trace_insn      = w_insn;
    assign o_trace_rd_we     = w_rd_we;
    assign o_trace_rd_sel    = w_rd_sel;
    assign o_trace_rd_data   = wb_data;
    assign o_trace_nzp_we    = w_nzp_we;
    assign o_trace_nzp       = nzp_of(wb_data);
    assign o_trace_dmem_we   = w_is_store;
    assign o_trace_dmem_addr = w_mem_addr;
    assign o_trace_dmem_data = w_mem_data;

    // data memory is written only by a STR sitting in M
    a_dmem_we_store: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> m_insn[15:12] == lc4_pkg::OP_STR);

endmodule

// File: include/lc4_tb_iss.svh
// instruction-set model, random program generator and memories for the LC4 testbench
// included inside the lc4_tb module body; the model steps once per retired instruction
`ifndef LC4_TB_ISS_SVH
`define LC4_TB_ISS_SVH

localparam int MEM_WORDS = 256;
localparam lc4_pkg::word_t SELF_BR = 16'h0FFF;   // BRnzp to itself

logic [31:0]     lfsr = 32'hddd0_bec1;
lc4_pkg::word_t  imem [MEM_WORDS];
lc4_pkg::word_t  dmem [MEM_WORDS];      // memory seen by the DUT
lc4_pkg::word_t  ref_mem [MEM_WORDS];   // memory of the model
lc4_pkg::word_t  ref_regs [8];
lc4_pkg::word_t  ref_pc;
lc4_pkg::nzp_t   ref_nzp;
int              prog_len;

// what the model expects from the next retiring slot
lc4_pkg::word_t  exp_pc, exp_insn, exp_rd_data, exp_mem_addr, exp_mem_data;
lc4_pkg::rsel_t  exp_rd_sel;
logic            exp_rd_we, exp_is_load, exp_is_store, exp_taken;

function automatic lc4_pkg::word_t sext(input lc4_pkg::word_t v, input int bits);
    lc4_pkg::word_t s;
    s = v;
    for (int i = bits; i < 16; i++)
        s[i] = v[bits-1];
    return s;
endfunction

function automatic lc4_pkg::nzp_t sign_class(input lc4_pkg::word_t v);
    if (v == 16'h0000)
        return 3'b010;
    return v[15] ? 3'b100 : 3'b001;
endfunction

// galois step, one call per bit taken
function logic next_bit();
    next_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (next_bit)
        lfsr = lfsr ^ 32'h8020_0003;
endfunction

function logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
        r = {r[14:0], next_bit()};
    return r;
endfunction

task automatic put(input lc4_pkg::word_t w);
    imem[prog_len[7:0]] = w;
    prog_len++;
endtask

task automatic init_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
        imem[i]    = '0;   // BR with no condition bits is a no-op
        dmem[i]    = {i[7:0], ~i[7:0]} ^ 16'h3c5a;
        ref_mem[i] = {i[7:0], ~i[7:0]} ^ 16'h3c5a;
    end
    for (int r = 0; r < 8; r++)
        ref_regs[r] = '0;
    ref_nzp = '0;
endtask

task automatic build_program();
    logic [15:0] kind, rd, rs, rt, imm, sub;
    logic [2:0]  prev_rd;
    prog_len = 0;
    prev_rd  = '0;
    for (int r = 0; r < 8; r++) begin
        imm = rand_bits(9);
        put({4'h9, r[2:0], imm[8:0]});   // give every register a value first
    end
    while (prog_len < MEM_WORDS - 12) begin
        kind = rand_bits(3);
        rd   = rand_bits(3);
        rs   = rand_bits(3);
        rt   = rand_bits(3);
        imm  = rand_bits(9);
        sub  = rand_bits(2);
        if (rand_bits(1) == 16'd1)
            rs[2:0] = prev_rd;   // back-to-back dependence
        case (kind[2:0])
            3'd0: put({4'h9, rd[2:0], imm[8:0]});
            3'd1: put(sub[1] ? {4'h1, rd[2:0], rs[2:0], 1'b1, imm[4:0]}
                             : {4'h1, rd[2:0], rs[2:0], 1'b0, sub[0], 1'b0, rt[2:0]});
            3'd2: put(sub == 16'd3 ? {4'h5, rd[2:0], rs[2:0], 1'b1, imm[4:0]}
                                   : {4'h5, rd[2:0], rs[2:0], 1'b0, sub[1] | sub[0], sub[1],
                                      rt[2:0]});   // AND, OR, XOR
            3'd3: put({4'h6, rd[2:0], rs[2:0], imm[5:0]});
            3'd4: put({4'h7, rt[2:0], rs[2:0], imm[5:0]});
            3'd5: begin
                put({4'h6, rd[2:0], rs[2:0], imm[5:0]});
                put({4'h1, rt[2:0], rd[2:0], 3'b000, rs[2:0]});   // load then use
            end
            3'd6: begin
                put({4'h6, rd[2:0], rs[2:0], imm[5:0]});
                put({4'h0, rt[2:0], 8'h00, sub[0]});   // load then branch
            end
            default: put({4'h0, rt[2:0], 7'h00, sub[1:0]});   // forward skip of 0..3
        endcase
        prev_rd = rd[2:0];
    end
    for (int i = 0; i < 4; i++)
        put({4'h9, i[2:0], 9'h011});   // landing area for late forward branches
    put(SELF_BR);
endtask

function automatic logic iss_reads(input lc4_pkg::word_t insn, input lc4_pkg::rsel_t sel);
    case (insn[15:12])
        4'h1, 4'h5: return insn[8:6] == sel || (!insn[5] && insn[2:0] == sel);
        4'h6, 4'h7: return insn[8:6] == sel;   // store data goes through WM
        default:    return 1'b0;
    endcase
endfunction

task automatic iss_step(input lc4_pkg::word_t insn);
    lc4_pkg::word_t a, b;
    logic [2:0]     sub;
    a   = ref_regs[insn[8:6]];
    b   = insn[5] ? sext(insn, 5) : ref_regs[insn[2:0]];
    sub = insn[5:3];
    exp_pc = ref_pc;
    exp_insn = insn;
    exp_rd_we = 1'b0;
    exp_rd_sel = insn[11:9];
    exp_rd_data = '0;
    exp_is_load = 1'b0;
    exp_is_store = 1'b0;
    exp_mem_addr = '0;
    exp_mem_data = '0;
    exp_taken = 1'b0;
    ref_pc = ref_pc + 16'd1;
    case (insn[15:12])
        4'h0: if (|(ref_nzp & insn[11:9])) begin
            exp_taken = 1'b1;
            ref_pc = ref_pc + sext(insn, 9);
        end
        4'h1: begin
            exp_rd_we = 1'b1;
            exp_rd_data = (!insn[5] && sub == 3'b010) ? a - b : a + b;
        end
        4'h5: begin
            exp_rd_we = 1'b1;
            if (insn[5])
                exp_rd_data = a & b;
            else if (sub == 3'b010)
                exp_rd_data = a | b;
            else if (sub == 3'b011)
                exp_rd_data = a ^ b;
            else
                exp_rd_data = a & b;
        end
        4'h6: begin
            exp_is_load = 1'b1;
            exp_rd_we = 1'b1;
            exp_mem_addr = a + sext(insn, 6);
            exp_mem_data = ref_mem[exp_mem_addr[7:0]];
            exp_rd_data = exp_mem_data;
        end
        4'h7: begin
            exp_is_store = 1'b1;
            exp_mem_addr = a + sext(insn, 6);
            exp_mem_data = ref_regs[insn[11:9]];
            ref_mem[exp_mem_addr[7:0]] = exp_mem_data;
        end
        4'h9: begin
            exp_rd_we = 1'b1;
            exp_rd_data = sext(insn, 9);
        end
        default: ;
    endcase
    if (exp_rd_we) begin
        ref_regs[exp_rd_sel] = exp_rd_data;
        ref_nzp = sign_class(exp_rd_data);
    end
endtask

`endif

// File: dv/lc4_tb.sv
// testbench for the LC4 pipeline: runs a random program with fixed hazard patterns
// and checks every retiring trace slot against the instruction-set model
`timescale 1ns/1ps

module lc4_tb;

    localparam lc4_pkg::word_t RESET_PC = lc4_pkg::DEFAULT_RESET_PC;
    localparam int RUN_TIMEOUT = 4000;   // cycles

    logic            gwe, i_arst_n;
    lc4_pkg::word_t  i_cur_insn, i_cur_dmem_data, fetch_off;
    lc4_pkg::word_t  o_cur_pc, o_dmem_addr, o_dmem_towrite;
    logic            o_dmem_we;
    lc4_pkg::stall_e o_trace_stall;
    lc4_pkg::word_t  o_trace_pc, o_trace_insn, o_trace_rd_data;
    lc4_pkg::word_t  o_trace_dmem_addr, o_trace_dmem_data;
    logic            o_trace_rd_we, o_trace_nzp_we, o_trace_dmem_we;
    lc4_pkg::rsel_t  o_trace_rd_sel;
    lc4_pkg::nzp_t   o_trace_nzp;

    int              err_val = 0;
    int              err_other = 0;
    int              self_hits = 0;
    int              ld_bubbles = 0;
    int              br_bubbles = 0;
    int              cycles;
    logic            checking = 1'b0;
    logic            done = 1'b0;
    logic            have_prev = 1'b0;
    logic            prev_load, prev_taken;
    lc4_pkg::rsel_t  prev_rd;

    `include "lc4_tb_iss.svh"

    lc4_pipeline #(.RESET_PC(RESET_PC)) dut_i (.*);

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // same-cycle instruction and data memories
    assign fetch_off       = o_cur_pc - RESET_PC;
    assign i_cur_insn      = (fetch_off[15:8] == 8'd0) ? imem[fetch_off[7:0]] : '0;
    assign i_cur_dmem_data = dmem[o_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_we)
            dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
    end

    task automatic check_eq(input string name, input lc4_pkg::word_t exp, act);
        assert (exp === act) else begin
            err_val++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reset_outputs();
        check_eq("reset pc", RESET_PC, o_cur_pc);
        check_eq("reset dmem_we", 16'd0, {15'd0, o_dmem_we});
        check_eq("reset rd_we", 16'd0, {15'd0, o_trace_rd_we});
        check_eq("reset nzp_we", 16'd0, {15'd0, o_trace_nzp_we});
    endtask

    task automatic retire_slot();
        lc4_pkg::word_t exp_ld, exp_br;
        iss_step(imem[ref_pc[7:0] - RESET_PC[7:0]]);
        if (have_prev) begin
            exp_ld = (prev_load && (iss_reads(exp_insn, prev_rd) || exp_insn[15:12] == 4'h0))
                     ? 16'd1 : 16'd0;
            exp_br = prev_taken ? 16'd2 : 16'd0;
            check_eq("load stall bubbles", exp_ld, lc4_pkg::word_t'(ld_bubbles));
            check_eq("branch flush bubbles", exp_br, lc4_pkg::word_t'(br_bubbles));
        end
        check_eq("retire pc", exp_pc, o_trace_pc);
        check_eq("retire insn", exp_insn, o_trace_insn);
        check_eq("rd_we", {15'd0, exp_rd_we}, {15'd0, o_trace_rd_we});
        check_eq("nzp_we", {15'd0, exp_rd_we}, {15'd0, o_trace_nzp_we});
        if (exp_rd_we) begin
            check_eq("rd_sel", {13'd0, exp_rd_sel}, {13'd0, o_trace_rd_sel});
            check_eq("rd_data", exp_rd_data, o_trace_rd_data);
            check_eq("trace nzp", {13'd0, ref_nzp}, {13'd0, o_trace_nzp});
        end
        check_eq("dmem_we", {15'd0, exp_is_store}, {15'd0, o_trace_dmem_we});
        if (exp_is_load || exp_is_store) begin
            check_eq("dmem addr", exp_mem_addr, o_trace_dmem_addr);
            check_eq("dmem data", exp_mem_data, o_trace_dmem_data);
        end
        have_prev  = 1'b1;
        prev_load  = exp_is_load;
        prev_taken = exp_taken;
        prev_rd    = exp_rd_sel;
        ld_bubbles = 0;
        br_bubbles = 0;
        if (exp_insn == SELF_BR)
            self_hits++;
        if (self_hits >= 3)
            done = 1'b1;
    endtask

    // trace sampled mid-cycle, away from the driving edge
    always @(negedge gwe) begin
        if (checking && !done) begin
            if (o_trace_stall == lc4_pkg::STALL_LOAD)
                ld_bubbles++;
            else if (o_trace_stall == lc4_pkg::STALL_BRANCH)
                br_bubbles++;
            else
                retire_slot();
        end
    end

    initial begin
        i_arst_n = 1'b0;
        init_memories();
        build_program();
        ref_pc = RESET_PC;
        repeat (4) begin
            @(negedge gwe);
            check_reset_outputs();
        end
        @(posedge gwe);
        #1 i_arst_n = 1'b1;
        checking = 1'b1;
        @(negedge gwe);
        check_reset_outputs();   // first cycle out of reset
        cycles = 0;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(posedge gwe);
            cycles++;
        end
        if (!done) begin
            err_other++;
            $display("timeout: the program never reached its final self-branch");
        end
        $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
rtl/lc4_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_alu.sv
rtl/lc4_regfile.sv
rtl/lc4_hazard_unit.sv
rtl/lc4_pipeline.sv
dv/lc4_tb.sv

// File: Makefile
# Verilator flow for the LC4 pipeline testbench

TOP = lc4_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f rtl/*.sv dv/*.sv include/*.svh
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
